// File: verilog/cpu_types_pkg.sv
package cpu_types_pkg;

	localparam int word_width = 32;
	localparam int reg_width = 5;
	localparam int reg_count = 1 << reg_width;

	typedef logic [word_width-1:0] word_t;
	typedef logic [reg_width-1:0] regbits_t;

	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		ADDIU = 6'h09,
		SLTI  = 6'h0a,
		ANDI  = 6'h0c,
		ORI   = 6'h0d,
		XORI  = 6'h0e,
		LUI   = 6'h0f,
		HALT  = 6'h3f
	} opcode_t;

	typedef enum logic [5:0] {
		SLL  = 6'h00,
		SRL  = 6'h02,
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		XOR  = 6'h26,
		NOR  = 6'h27,
		SLT  = 6'h2a,
		SLTU = 6'h2b
	} funct_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_lui
	} aluop_t;

	// second operand source
	typedef enum logic [1:0] {
		src_reg, src_imm, src_shamt
	} alusrc_t;

	typedef struct packed {
		opcode_t    opcode;
		regbits_t   rs;
		regbits_t   rt;
		regbits_t   rd;
		logic [4:0] shamt;
		funct_t     funct;
	} r_type_t;

	typedef struct packed {
		opcode_t     opcode;
		regbits_t    rs;
		regbits_t    rt;
		logic [15:0] imm;
	} i_type_t;

	typedef union packed {
		r_type_t r;
		i_type_t i;
	} instr_t;

	typedef struct packed {
		logic       valid;
		aluop_t     aluop;
		alusrc_t    alusrc;
		logic       regwrite;
		logic       halt;
		regbits_t   wsel;
		word_t      rdat_one;
		word_t      rdat_two;
		word_t      extimm;
		logic [4:0] shamt;
	} id_ex_t;

	typedef struct packed {
		logic     wen;
		regbits_t wsel;
		word_t    wdat;
	} wb_t;

endpackage

// File: verilog/register_file.sv
module register_file (
	input  logic                   CLK,
	input  logic                   nRST,
	input  cpu_types_pkg::wb_t     wb,
	input  logic                   stall,
	input  cpu_types_pkg::regbits_t rsel_one,
	input  cpu_types_pkg::regbits_t rsel_two,
	output cpu_types_pkg::word_t   rdat_one,
	output cpu_types_pkg::word_t   rdat_two
);
	import cpu_types_pkg::*;

	word_t regs [1:reg_count-1]; // r0 is hardwired
	logic we;

	assign we = wb.wen && !stall && (wb.wsel != '0);

	// write data shows through on the same cycle
	function automatic word_t read_port(regbits_t sel);
		word_t rdat;
		if (sel == '0)
			rdat = '0;
		else if (we && sel == wb.wsel)
			rdat = wb.wdat;
		else
			rdat = regs[sel];
		return rdat;
	endfunction

	always_comb begin
		rdat_one = read_port(rsel_one);
		rdat_two = read_port(rsel_two);
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 1; i < reg_count; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wb.wsel] <= wb.wdat;
		end
	end

endmodule

// File: verilog/decode_stage.sv
module decode_stage (
	input  cpu_types_pkg::instr_t   instr,
	input  logic                    instr_valid,
	output cpu_types_pkg::regbits_t rsel_one,
	output cpu_types_pkg::regbits_t rsel_two,
	input  cpu_types_pkg::word_t    rdat_one,
	input  cpu_types_pkg::word_t    rdat_two,
	output cpu_types_pkg::id_ex_t   decoded
);
	import cpu_types_pkg::*;

	logic zero_ext;

	assign rsel_one = instr.r.rs;
	assign rsel_two = instr.r.rt;

	// logical immediates are zero extended
	assign zero_ext = (instr.i.opcode == ANDI) || (instr.i.opcode == ORI) ||
		(instr.i.opcode == XORI);

	always_comb begin
		decoded = '0;
		decoded.valid = instr_valid;
		decoded.aluop = alu_add;
		decoded.alusrc = src_reg;
		decoded.rdat_one = rdat_one;
		decoded.rdat_two = rdat_two;
		decoded.shamt = instr.r.shamt;
		decoded.wsel = instr.i.rt; // I-type target by default
		if (zero_ext)
			decoded.extimm = {16'h0000, instr.i.imm};
		else
			decoded.extimm = {{16{instr.i.imm[15]}}, instr.i.imm};

		case (instr.i.opcode)
			RTYPE: begin
				decoded.wsel = instr.r.rd;
				decoded.regwrite = 1'b1;
				case (instr.r.funct)
					ADDU: decoded.aluop = alu_add;
					SUBU: decoded.aluop = alu_sub;
					AND:  decoded.aluop = alu_and;
					OR:   decoded.aluop = alu_or;
					XOR:  decoded.aluop = alu_xor;
					NOR:  decoded.aluop = alu_nor;
					SLT:  decoded.aluop = alu_slt;
					SLTU: decoded.aluop = alu_sltu;
					SLL: begin
						decoded.aluop = alu_sll;
						decoded.alusrc = src_shamt;
					end
					SRL: begin
						decoded.aluop = alu_srl;
						decoded.alusrc = src_shamt;
					end
					default: decoded.regwrite = 1'b0; // unknown funct is a nop
				endcase
			end
			ADDIU, ANDI, ORI, XORI, SLTI, LUI: begin
				decoded.alusrc = src_imm;
				decoded.regwrite = 1'b1;
				case (instr.i.opcode)
					ANDI:    decoded.aluop = alu_and;
					ORI:     decoded.aluop = alu_or;
					XORI:    decoded.aluop = alu_xor;
					SLTI:    decoded.aluop = alu_slt;
					LUI:     decoded.aluop = alu_lui;
					default: decoded.aluop = alu_add;
				endcase
			end
			HALT: decoded.halt = 1'b1;
			default: ;
		endcase

		if (decoded.wsel == '0)
			decoded.regwrite = 1'b0; // r0 never written
	end

endmodule

// File: verilog/id_ex_latch.sv
module id_ex_latch (
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  stall,
	input  cpu_types_pkg::id_ex_t decoded,
	output cpu_types_pkg::id_ex_t latched
);

	// holds the decoded instruction while stalled
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			latched <= '0;
		end else if (!stall) begin
			latched <= decoded;
		end
	end

	halt_no_write: assert property (@(posedge CLK) disable iff (!nRST)
		latched.halt |-> !latched.regwrite);

endmodule

// File: verilog/execute_stage.sv
module execute_stage (
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  stall,
	input  cpu_types_pkg::id_ex_t latched,
	output cpu_types_pkg::wb_t    wb,
	output logic                  halted
);
	import cpu_types_pkg::*;

	word_t opa, opb, result;

	always_comb begin
		opa = latched.rdat_one;
		opb = latched.rdat_two;
		case (latched.alusrc)
			src_imm: opb = latched.extimm;
			src_shamt: begin
				opa = latched.rdat_two; // shifts act on rt
				opb = {{(word_width-5){1'b0}}, latched.shamt};
			end
			default: ;
		endcase
	end

	always_comb begin
		case (latched.aluop)
			alu_add:  result = opa + opb;
			alu_sub:  result = opa - opb;
			alu_and:  result = opa & opb;
			alu_or:   result = opa | opb;
			alu_xor:  result = opa ^ opb;
			alu_nor:  result = ~(opa | opb);
			alu_slt:  result = word_t'($signed(opa) < $signed(opb));
			alu_sltu: result = word_t'(opa < opb);
			alu_sll:  result = opa << opb[4:0];
			alu_srl:  result = opa >> opb[4:0];
			alu_lui:  result = {opb[15:0], 16'h0000};
			default:  result = '0;
		endcase
	end

	always_comb begin
		wb.wen = latched.valid && latched.regwrite && !halted;
		wb.wsel = latched.wsel;
		wb.wdat = result;
	end

	// sticky until reset
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			halted <= 1'b0;
		end else if (!stall && latched.valid && latched.halt) begin
			halted <= 1'b1;
		end
	end

	no_r0_write: assert property (@(posedge CLK) disable iff (!nRST)
		wb.wen |-> (wb.wsel != '0));

endmodule

// File: verilog/datapath_top.sv
module datapath_top (
	input  logic                  CLK,
	input  logic                  nRST,
	input  cpu_types_pkg::instr_t instr,
	input  logic                  instr_valid,
	input  logic                  stall,
	output cpu_types_pkg::wb_t    wb,
	output logic                  halted
);
	import cpu_types_pkg::*;

	regbits_t rsel_one, rsel_two;
	word_t rdat_one, rdat_two;
	id_ex_t decoded, latched;

	register_file u_regs (
		.CLK      (CLK),
		.nRST     (nRST),
		.wb       (wb),
		.stall    (stall),
		.rsel_one (rsel_one),
		.rsel_two (rsel_two),
		.rdat_one (rdat_one),
		.rdat_two (rdat_two)
	);

	decode_stage u_decode (
		.instr       (instr),
		.instr_valid (instr_valid),
		.rsel_one    (rsel_one),
		.rsel_two    (rsel_two),
		.rdat_one    (rdat_one),
		.rdat_two    (rdat_two),
		.decoded     (decoded)
	);

	id_ex_latch u_id_ex (
		.CLK     (CLK),
		.nRST    (nRST),
		.stall   (stall),
		.decoded (decoded),
		.latched (latched)
	);

	execute_stage u_execute (
		.CLK     (CLK),
		.nRST    (nRST),
		.stall   (stall),
		.latched (latched),
		.wb      (wb),
		.halted  (halted)
	);

endmodule

// File: tests/datapath_tb.sv
module datapath_tb;
	import cpu_types_pkg::*;

	logic CLK, nRST, instr_valid, stall;
	instr_t instr;
	wb_t wb;
	logic halted;

	word_t model_regs [reg_count];
	logic halted_model;
	logic [31:0] lcg_state;
	int errors, checks;

	datapath_top dut (
		.CLK         (CLK),
		.nRST        (nRST),
		.instr       (instr),
		.instr_valid (instr_valid),
		.stall       (stall),
		.wb          (wb),
		.halted      (halted)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic regbits_t pick_reg(); // r1 .. r15
		return regbits_t'(rand_next() % 32'd15 + 32'd1);
	endfunction

	function automatic instr_t r_word(funct_t f, regbits_t rd, regbits_t rs, regbits_t rt,
		logic [4:0] sh);
		instr_t w;
		w.r.opcode = RTYPE;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.shamt = sh;
		w.r.funct = f;
		return w;
	endfunction

	function automatic instr_t i_word(opcode_t op, regbits_t rs, regbits_t rt, logic [15:0] imm);
		instr_t w;
		w.i.opcode = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm = imm;
		return w;
	endfunction

	// reference result from the instruction set rules and the model registers
	function automatic wb_t predict_wb(instr_t w);
		wb_t e;
		word_t a, b, simm, zimm;
		a = model_regs[w.i.rs];
		b = model_regs[w.i.rt];
		simm = {{16{w.i.imm[15]}}, w.i.imm};
		zimm = {16'h0000, w.i.imm};
		e = '0;
		e.wen = 1'b1;
		e.wsel = w.i.rt;
		case (w.i.opcode)
			RTYPE: begin
				e.wsel = w.r.rd;
				case (w.r.funct)
					ADDU: e.wdat = a + b;
					SUBU: e.wdat = a - b;
					AND:  e.wdat = a & b;
					OR:   e.wdat = a | b;
					XOR:  e.wdat = a ^ b;
					NOR:  e.wdat = ~(a | b);
					SLT:  e.wdat = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					SLTU: e.wdat = (a < b) ? 32'd1 : 32'd0;
					SLL:  e.wdat = b << w.r.shamt;
					SRL:  e.wdat = b >> w.r.shamt;
					default: e.wen = 1'b0;
				endcase
			end
			ADDIU: e.wdat = a + simm;
			SLTI:  e.wdat = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
			ANDI:  e.wdat = a & zimm;
			ORI:   e.wdat = a | zimm;
			XORI:  e.wdat = a ^ zimm;
			LUI:   e.wdat = {w.i.imm, 16'h0000};
			default: e.wen = 1'b0; // HALT and unknown opcodes write nothing
		endcase
		if (e.wsel == '0 || halted_model)
			e.wen = 1'b0;
		return e;
	endfunction

	task automatic update_model(wb_t e);
		if (e.wen)
			model_regs[e.wsel] = e.wdat;
	endtask

	task automatic compare_wb(wb_t got, wb_t exp, string what);
		checks++;
		if (got.wen !== exp.wen || (exp.wen && (got.wsel !== exp.wsel || got.wdat !== exp.wdat))) begin
			errors++;
			$display("[FAIL] %0t: %s wb wen=%0b r%0d=%h, expected wen=%0b r%0d=%h", $time, what,
				got.wen, got.wsel, got.wdat, exp.wen, exp.wsel, exp.wdat);
		end
	endtask

	task automatic verify_halted(logic got, logic exp, string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t: %s halted=%0b, expected %0b", $time, what, got, exp);
		end
	endtask

	// accepted at the second edge, wb sampled mid cycle after it
	task automatic run_instr(instr_t w, string what);
		wb_t exp;
		exp = predict_wb(w);
		@(posedge CLK);
		instr <= w;
		instr_valid <= 1'b1;
		@(posedge CLK);
		instr_valid <= 1'b0;
		@(negedge CLK);
		compare_wb(wb, exp, what);
		update_model(exp);
	endtask

	task automatic wait_for_halt();
		int n;
		n = 0;
		while (halted !== 1'b1 && n < 20) begin
			@(negedge CLK);
			n++;
		end
		if (halted !== 1'b1) begin
			errors++;
			$display("timeout: halted was not set within 20 cycles of the HALT");
		end
	endtask

	task automatic load_immediates();
		word_t v;
		regbits_t r;
		for (int k = 1; k < 16; k++) begin
			v = rand_next();
			r = regbits_t'(k);
			run_instr(i_word(LUI, 5'd0, r, v[31:16]), "lui upper half");
			run_instr(i_word(ORI, r, r, v[15:0]), "ori lower half");
		end
	endtask

	task automatic alu_r_ops();
		funct_t ops [10];
		logic [31:0] rnd;
		ops = '{ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU, SLL, SRL};
		for (int k = 0; k < 20; k++) begin
			rnd = rand_next();
			run_instr(r_word(ops[k % 10], regbits_t'(16 + k % 8), pick_reg(), pick_reg(), rnd[4:0]),
				"r-type alu");
		end
	endtask

	task automatic imm_extension();
		run_instr(i_word(ORI, 5'd0, 5'd1, 16'h0010), "ori setup");
		run_instr(i_word(ADDIU, 5'd1, 5'd2, 16'hfff0), "addiu negative");
		run_instr(i_word(ADDIU, 5'd0, 5'd3, 16'h8000), "addiu sign bit");
		run_instr(i_word(SLTI, 5'd0, 5'd4, 16'hffff), "slti negative");
		run_instr(i_word(SLTI, 5'd3, 5'd5, 16'hffff), "slti both negative");
		run_instr(i_word(ANDI, 5'd3, 5'd6, 16'hffff), "andi zero extend");
		run_instr(i_word(XORI, 5'd3, 5'd7, 16'h8000), "xori zero extend");
	endtask

	task automatic back_to_back();
		instr_t chain [6];
		wb_t exp [6];
		regbits_t prev, dst;
		prev = 5'd1;
		for (int k = 0; k < 6; k++) begin
			dst = regbits_t'(20 + k);
			case (k % 3)
				0: chain[k] = r_word(ADDU, dst, prev, prev, 5'd0);
				1: chain[k] = i_word(ADDIU, prev, dst, 16'h8001);
				default: chain[k] = r_word(SLL, dst, 5'd0, prev, 5'd3);
			endcase
			exp[k] = predict_wb(chain[k]);
			update_model(exp[k]);
			prev = dst;
		end
		for (int k = 0; k <= 6; k++) begin
			@(posedge CLK);
			if (k < 6) begin
				instr <= chain[k];
				instr_valid <= 1'b1;
			end else
				instr_valid <= 1'b0;
			if (k > 0) begin
				@(negedge CLK);
				compare_wb(wb, exp[k-1], "back-to-back");
			end
		end
	endtask

	task automatic stall_hold();
		instr_t w_one, w_two;
		wb_t exp_one, exp_two;
		w_one = i_word(ADDIU, 5'd9, 5'd9, 16'h0001); // counts how often it commits
		w_two = r_word(ADDU, 5'd10, 5'd9, 5'd0, 5'd0);
		exp_one = predict_wb(w_one);
		update_model(exp_one);
		exp_two = predict_wb(w_two);
		update_model(exp_two);
		@(posedge CLK);
		instr <= w_one;
		instr_valid <= 1'b1;
		@(posedge CLK);
		stall <= 1'b1;
		instr <= w_two; // held by the source while stalled
		for (int k = 0; k < 4; k++) begin
			@(negedge CLK);
			compare_wb(wb, exp_one, "held under stall");
			@(posedge CLK);
		end
		stall <= 1'b0;
		@(posedge CLK);
		instr_valid <= 1'b0;
		@(negedge CLK);
		compare_wb(wb, exp_two, "first after stall");
		run_instr(r_word(ADDU, 5'd11, 5'd9, 5'd0, 5'd0), "single commit under stall");
	endtask

	task automatic r0_and_halt();
		run_instr(i_word(ADDIU, 5'd1, 5'd0, 16'h0005), "write to r0");
		run_instr(r_word(OR, 5'd12, 5'd0, 5'd0, 5'd0), "r0 reads zero");
		verify_halted(halted, 1'b0, "before halt");
		run_instr(i_word(HALT, 5'd0, 5'd0, 16'h0000), "halt");
		wait_for_halt();
		verify_halted(halted, 1'b1, "halt committed");
		halted_model = 1'b1;
		run_instr(i_word(ADDIU, 5'd1, 5'd14, 16'h0001), "after halt");
		verify_halted(halted, 1'b1, "halt sticky");
	endtask

	initial begin
		errors = 0;
		checks = 0;
		lcg_state = 32'h4bff_9a39;
		halted_model = 1'b0;
		for (int i = 0; i < reg_count; i++)
			model_regs[i] = '0;
		nRST = 1'b0;
		stall = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		repeat (5) @(posedge CLK);
		nRST <= 1'b1;
		@(negedge CLK);
		verify_halted(halted, 1'b0, "after reset");
		compare_wb(wb, '0, "after reset");
		load_immediates();
		alu_r_ops();
		imm_extension();
		back_to_back();
		stall_hold();
		r0_and_halt();
		repeat (2) @(posedge CLK);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: build.f
verilog/cpu_types_pkg.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/id_ex_latch.sv
verilog/execute_stage.sv
verilog/datapath_top.sv
tests/datapath_tb.sv

// File: run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module datapath_tb \
	-Mdir obj_dir -o datapath_sim > build.log 2>&1 \
	&& ./obj_dir/datapath_sim > sim.log 2>&1 \
	|| { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "Test FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "Test OK" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
